// ==== all.f ====
+incdir+include
hw/cpuPkg.sv
hw/aluUnit.sv
hw/registerFile.sv
hw/controlUnit.sv
hw/datapath.sv
hw/cpuTop.sv
bench/cpuTop_sva.sv
bench/cpuTop_tb.sv

// ==== bench/cpuTop_sva.sv ====
`default_nettype none

module cpuTop_sva (
	input logic clk,
	input logic reset_n,
	input logic readM,
	input logic writeM,
	input logic halted
);

	// one memory port allows one access at a time
	strobeExclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(readM && writeM))
		else $error("readM and writeM high in the same cycle");

	resetClears: assert property (@(posedge clk)
		!reset_n |=> (!readM && !writeM && !halted))
		else $error("strobes or halted not low after a reset edge");

	// only a reset leaves the halted state
	haltSticky: assert property (@(posedge clk) disable iff (!reset_n)
		halted |=> halted)
		else $error("halted dropped without a reset");

	haltQuiet: assert property (@(posedge clk) disable iff (!reset_n)
		halted |-> (!readM && !writeM))
		else $error("memory strobe while halted");

endmodule

`default_nettype wire

// ==== bench/cpuTop_tb.sv ====
`default_nettype none

`include "cpu_defines.svh"

module cpuTop_tb import cpuPkg::*; ();

	localparam int numTests = 5;
	localparam int maxWords = 32;
	localparam int maxOuts = 10;
	localparam int maxMems = 2;
	localparam int haltTimeout = 2000;
	localparam int idleCycles = 20;

	logic clk;
	logic reset_n;
	logic readM;
	logic writeM;
	word_t address;
	word_t writeData;
	word_t readData;
	word_t outputPort;
	logic halted;

	word_t mem [256];

	// program table with one row per test
	word_t progImage [numTests][maxWords];
	int progLen [numTests];
	word_t expOut [numTests][maxOuts];
	int outLen [numTests];
	logic [7:0] expMemAddr [numTests][maxMems];
	word_t expMemData [numTests][maxMems];
	int memLen [numTests];
	int expCycles [numTests];

	int errorCount;
	int checkCount;

	cpuTop i_dut (
		.clk(clk),
		.reset_n(reset_n),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.writeData(writeData),
		.readData(readData),
		.outputPort(outputPort),
		.halted(halted)
	);

	bind cpuTop cpuTop_sva i_sva (
		.clk(clk),
		.reset_n(reset_n),
		.readM(readM),
		.writeM(writeM),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// memory answers on the falling edge and stores on the rising edge
	always @(negedge clk) begin
		readData = (readM === 1'b1) ? mem[address[7:0]] : '0;
	end

	always @(posedge clk) begin
		if (writeM === 1'b1) begin
			mem[address[7:0]] = writeData;
		end
	end

	function automatic word_t rInstr(input regIdx_t rs, input regIdx_t rt,
		input regIdx_t rd, input func_t func);
		return {`RTYPE_OP, rs, rt, rd, func};
	endfunction

	function automatic word_t iInstr(input opcode_t op, input regIdx_t rs,
		input regIdx_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jInstr(input opcode_t op, input logic [11:0] target);
		return {op, target};
	endfunction

	function automatic word_t wwdInstr(input regIdx_t rs);
		return rInstr(rs, 2'd0, 2'd0, `FUNC_WWD);
	endfunction

	function automatic word_t hltInstr();
		return rInstr(2'd0, 2'd0, 2'd0, `FUNC_HLT);
	endfunction

	task automatic placeWord(input int t, input word_t w);
		progImage[t][progLen[t]] = w;
		progLen[t]++;
	endtask

	// a WWD together with the value it must show
	task automatic placeWwd(input int t, input regIdx_t rs, input word_t value);
		placeWord(t, wwdInstr(rs));
		expOut[t][outLen[t]] = value;
		outLen[t]++;
	endtask

	task automatic expectMemWord(input int t, input logic [7:0] addr, input word_t value);
		expMemAddr[t][memLen[t]] = addr;
		expMemData[t][memLen[t]] = value;
		memLen[t]++;
	endtask

	task automatic checkValue(input string what, input word_t got, input word_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic buildTable();
		for (int t = 0; t < numTests; t++) begin
			progLen[t] = 0;
			outLen[t] = 0;
			memLen[t] = 0;
		end

		// register type ops on r1 = 5 and r2 = 3
		placeWord(0, iInstr(`ADI_OP, 2'd0, 2'd1, 8'h05));
		placeWord(0, iInstr(`ADI_OP, 2'd0, 2'd2, 8'h03));
		placeWord(0, rInstr(2'd1, 2'd2, 2'd3, `FUNC_ADD));
		placeWwd(0, 2'd3, 16'h0008);
		placeWord(0, rInstr(2'd1, 2'd2, 2'd3, `FUNC_SUB));
		placeWwd(0, 2'd3, 16'h0002);
		placeWord(0, rInstr(2'd1, 2'd2, 2'd3, `FUNC_AND));
		placeWwd(0, 2'd3, 16'h0001);
		placeWord(0, rInstr(2'd1, 2'd2, 2'd3, `FUNC_ORR));
		placeWwd(0, 2'd3, 16'h0007);
		placeWord(0, rInstr(2'd1, 2'd0, 2'd3, `FUNC_NOT));
		placeWwd(0, 2'd3, 16'hFFFA);
		placeWord(0, rInstr(2'd1, 2'd0, 2'd3, `FUNC_TCP));
		placeWwd(0, 2'd3, 16'hFFFB);
		// arithmetic shift of a negative value keeps the sign
		placeWord(0, rInstr(2'd3, 2'd0, 2'd3, `FUNC_SHR));
		placeWwd(0, 2'd3, 16'hFFFD);
		placeWord(0, rInstr(2'd1, 2'd0, 2'd3, `FUNC_SHL));
		placeWwd(0, 2'd3, 16'h000A);
		placeWord(0, hltInstr());
		expCycles[0] = 94;

		// immediates then code after HLT that must never run
		placeWord(1, iInstr(`ADI_OP, 2'd0, 2'd1, 8'hFE));
		placeWwd(1, 2'd1, 16'hFFFE);
		placeWord(1, iInstr(`ORI_OP, 2'd0, 2'd2, 8'h9C));
		placeWwd(1, 2'd2, 16'h009C);
		placeWord(1, iInstr(`LHI_OP, 2'd0, 2'd3, 8'hA5));
		placeWwd(1, 2'd3, 16'hA500);
		placeWord(1, iInstr(`ADI_OP, 2'd3, 2'd3, 8'h81));
		placeWwd(1, 2'd3, 16'hA481);
		placeWord(1, hltInstr());
		placeWord(1, wwdInstr(2'd0));
		placeWord(1, iInstr(`SWD_OP, 2'd0, 2'd1, 8'h50));
		expectMemWord(1, 8'h50, 16'hC050);
		expCycles[1] = 44;

		// store and load back with positive and negative offsets from 0x40
		placeWord(2, iInstr(`ADI_OP, 2'd0, 2'd1, 8'h40));
		placeWord(2, iInstr(`LHI_OP, 2'd0, 2'd2, 8'h12));
		placeWord(2, iInstr(`ORI_OP, 2'd2, 2'd2, 8'h34));
		placeWord(2, iInstr(`SWD_OP, 2'd1, 2'd2, 8'h05));
		placeWord(2, iInstr(`LWD_OP, 2'd1, 2'd3, 8'h05));
		placeWwd(2, 2'd3, 16'h1234);
		placeWord(2, iInstr(`ADI_OP, 2'd3, 2'd2, 8'h01));
		placeWord(2, iInstr(`SWD_OP, 2'd1, 2'd2, 8'hFE));
		placeWord(2, iInstr(`LWD_OP, 2'd1, 2'd0, 8'hFE));
		placeWwd(2, 2'd0, 16'h1235);
		placeWord(2, hltInstr());
		expectMemWord(2, 8'h45, 16'h1234);
		expectMemWord(2, 8'h3E, 16'h1235);
		expCycles[2] = 60;

		// branches on r1 = r2 = 5 and r3 = -3 where skipped markers would show 0
		placeWord(3, iInstr(`ADI_OP, 2'd0, 2'd1, 8'h05));
		placeWord(3, iInstr(`ADI_OP, 2'd0, 2'd2, 8'h05));
		placeWord(3, iInstr(`ADI_OP, 2'd0, 2'd3, 8'hFD));
		placeWwd(3, 2'd1, 16'h0005);
		placeWord(3, iInstr(`BNE_OP, 2'd1, 2'd2, 8'h01));
		placeWwd(3, 2'd3, 16'hFFFD);
		placeWord(3, iInstr(`BEQ_OP, 2'd1, 2'd2, 8'h01));
		placeWord(3, wwdInstr(2'd0));
		placeWord(3, iInstr(`BNE_OP, 2'd1, 2'd3, 8'h01));
		placeWord(3, wwdInstr(2'd0));
		placeWwd(3, 2'd1, 16'h0005);
		placeWord(3, iInstr(`BEQ_OP, 2'd1, 2'd3, 8'h01));
		placeWwd(3, 2'd3, 16'hFFFD);
		placeWord(3, iInstr(`BGZ_OP, 2'd1, 2'd0, 8'h01));
		placeWord(3, wwdInstr(2'd0));
		placeWwd(3, 2'd1, 16'h0005);
		placeWord(3, iInstr(`BGZ_OP, 2'd3, 2'd0, 8'h01));
		placeWwd(3, 2'd3, 16'hFFFD);
		placeWord(3, iInstr(`BLZ_OP, 2'd3, 2'd0, 8'h01));
		placeWord(3, wwdInstr(2'd0));
		placeWwd(3, 2'd1, 16'h0005);
		placeWord(3, iInstr(`BLZ_OP, 2'd1, 2'd0, 8'h01));
		placeWwd(3, 2'd3, 16'hFFFD);
		// backward loop of five passes counted in r0
		placeWord(3, iInstr(`ADI_OP, 2'd0, 2'd0, 8'h01));
		placeWord(3, iInstr(`ADI_OP, 2'd2, 2'd2, 8'hFF));
		placeWord(3, iInstr(`BGZ_OP, 2'd2, 2'd0, 8'hFD));
		placeWwd(3, 2'd0, 16'h0005);
		placeWord(3, hltInstr());
		expCycles[3] = 166;

		// jumps with links landing in r2
		placeWord(4, iInstr(`ADI_OP, 2'd0, 2'd1, 8'h11));
		placeWord(4, jInstr(`JMP_OP, 12'h004));
		placeWord(4, wwdInstr(2'd0));
		placeWord(4, hltInstr());
		placeWwd(4, 2'd1, 16'h0011);
		placeWord(4, jInstr(`JAL_OP, 12'h00A));
		placeWord(4, iInstr(`ADI_OP, 2'd0, 2'd3, 8'h0E));
		placeWord(4, rInstr(2'd3, 2'd0, 2'd0, `FUNC_JRL));
		expOut[4][3] = 16'h0011;
		placeWord(4, wwdInstr(2'd1));
		placeWord(4, hltInstr());
		// first subroutine at 10
		expOut[4][1] = 16'h0006;
		placeWord(4, wwdInstr(2'd2));
		placeWord(4, rInstr(2'd2, 2'd0, 2'd0, `FUNC_JPR));
		placeWord(4, wwdInstr(2'd0));
		placeWord(4, wwdInstr(2'd0));
		// second subroutine at 14
		expOut[4][2] = 16'h0008;
		placeWord(4, wwdInstr(2'd2));
		placeWord(4, rInstr(2'd2, 2'd0, 2'd0, `FUNC_JPR));
		outLen[4] = 4;
		expCycles[4] = 56;
	endtask

	task automatic runTest(input int t);
		int cycles;
		int outIdx;
		word_t lastOut;
		logic done;

		@(negedge clk);
		reset_n = 1'b0;
		for (int a = 0; a < 256; a++) begin
			mem[a] = {8'hC0, 8'(a)};
		end
		for (int i = 0; i < progLen[t]; i++) begin
			mem[i] = progImage[t][i];
		end
		repeat (2) @(negedge clk);
		reset_n = 1'b1;

		cycles = 0;
		outIdx = 0;
		lastOut = '0;
		done = 1'b0;
		while (!done && cycles < haltTimeout) begin
			@(negedge clk);
			cycles++;
			if (outputPort !== lastOut) begin
				if (outIdx < outLen[t]) begin
					checkValue($sformatf("test %0d output %0d", t, outIdx),
						outputPort, expOut[t][outIdx]);
				end
				outIdx++;
				lastOut = outputPort;
			end
			done = (halted === 1'b1);
		end

		if (!done) begin
			errorCount++;
			$display("timeout: test %0d did not halt within %0d cycles", t, haltTimeout);
		end else begin
			checkValue($sformatf("test %0d cycles to halt", t), word_t'(cycles),
				word_t'(expCycles[t]));
			// the core must stay frozen once halted
			for (int i = 0; i < idleCycles; i++) begin
				@(negedge clk);
				checkValue($sformatf("test %0d output after halt", t), outputPort, lastOut);
				checkValue($sformatf("test %0d strobes after halt", t),
					word_t'({readM, writeM}), 16'h0000);
			end
		end

		checkValue($sformatf("test %0d output count", t), word_t'(outIdx),
			word_t'(outLen[t]));
		for (int i = 0; i < memLen[t]; i++) begin
			checkValue($sformatf("test %0d mem[%0h]", t, expMemAddr[t][i]),
				mem[expMemAddr[t][i]], expMemData[t][i]);
		end
	endtask

	initial begin
		reset_n = 1'b0;
		readData = '0;
		errorCount = 0;
		checkCount = 0;
		buildTable();
		for (int t = 0; t < numTests; t++) begin
			runTest(t);
		end
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/aluUnit.sv ====
`default_nettype none

`include "cpu_defines.svh"

module aluUnit import cpuPkg::*; (
	input word_t a,
	input word_t b,
	input aluOp_t op,
	output word_t result,
	output logic overflow
);

	always_comb begin
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				result = a + b;
				// same operand signs but result sign flipped
				overflow = (a[`WORD_SIZE-1] == b[`WORD_SIZE-1]) &&
					(result[`WORD_SIZE-1] != a[`WORD_SIZE-1]);
			end
			ALU_SUB: begin
				result = a - b;
				overflow = (a[`WORD_SIZE-1] != b[`WORD_SIZE-1]) &&
					(result[`WORD_SIZE-1] != a[`WORD_SIZE-1]);
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_NOT: begin
				result = ~a;
			end
			ALU_TCP: begin
				result = ~a + 1'b1;
			end
			ALU_SHL: begin
				result = {a[`WORD_SIZE-2:0], 1'b0};
			end
			ALU_SHR: begin
				// arithmetic shift keeps the sign bit
				result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};
			end
			default: begin
				result = b;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`default_nettype none

`include "cpu_defines.svh"

module controlUnit import cpuPkg::*; (
	input logic clk,
	input logic reset_n,
	input word_t instruction,
	output ctrlWord_t ctrl,
	output logic halted
);

	opcode_t opcode;
	func_t func;
	ctrlWord_t dec;
	logic isHlt;
	logic shortInstr;
	microState_t state;
	microState_t nextState;

	assign opcode = instruction[15:12];
	assign func = instruction[5:0];

	// instruction decode independent of the state
	always_comb begin
		dec = '0;
		dec.aluOp = ALU_ADD;
		isHlt = 1'b0;
		case (opcode)
			`BNE_OP, `BEQ_OP, `BGZ_OP, `BLZ_OP: begin
				dec.branch = 1'b1;
				dec.aluSrcImm = 1'b1;
			end
			`ADI_OP: begin
				dec.aluSrcImm = 1'b1;
				dec.regWrite = 1'b1;
			end
			`ORI_OP: begin
				dec.aluOp = ALU_OR;
				dec.aluSrcImm = 1'b1;
				dec.regWrite = 1'b1;
			end
			`LHI_OP: begin
				dec.aluOp = ALU_PASSB;
				dec.aluSrcImm = 1'b1;
				dec.regWrite = 1'b1;
			end
			`LWD_OP: begin
				dec.aluSrcImm = 1'b1;
				dec.memRead = 1'b1;
				dec.memToReg = 1'b1;
				dec.regWrite = 1'b1;
			end
			`SWD_OP: begin
				dec.aluSrcImm = 1'b1;
				dec.memWrite = 1'b1;
			end
			`JMP_OP: begin
				dec.jump = 1'b1;
			end
			`JAL_OP: begin
				dec.jump = 1'b1;
				dec.linkToReg = 1'b1;
				dec.regWrite = 1'b1;
			end
			`RTYPE_OP: begin
				// function codes up to SHR are ALU ops writing rd
				dec.regDst = 1'b1;
				dec.regWrite = (func <= `FUNC_SHR);
				case (func)
					`FUNC_SUB: dec.aluOp = ALU_SUB;
					`FUNC_AND: dec.aluOp = ALU_AND;
					`FUNC_ORR: dec.aluOp = ALU_OR;
					`FUNC_NOT: dec.aluOp = ALU_NOT;
					`FUNC_TCP: dec.aluOp = ALU_TCP;
					`FUNC_SHL: dec.aluOp = ALU_SHL;
					`FUNC_SHR: dec.aluOp = ALU_SHR;
					`FUNC_JPR: dec.jumpReg = 1'b1;
					`FUNC_JRL: begin
						dec.jumpReg = 1'b1;
						dec.linkToReg = 1'b1;
						dec.regWrite = 1'b1;
					end
					`FUNC_WWD: dec.wwd = 1'b1;
					`FUNC_HLT: isHlt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// branch, JMP, JPR and HLT finish in EX
	assign shortInstr = dec.branch || isHlt ||
		((dec.jump || dec.jumpReg) && !dec.linkToReg);

	always_comb begin
		nextState = IF1;
		case (state)
			IF1: nextState = IF2;
			IF2: nextState = IF3;
			IF3: nextState = EX;
			EX: begin
				if (shortInstr) begin
					nextState = IF1;
				end else if (dec.memRead || dec.memWrite) begin
					nextState = MEM1;
				end else begin
					nextState = WB;
				end
			end
			MEM1: nextState = MEM2;
			MEM2: nextState = dec.memRead ? WB : IF1;
			default: nextState = IF1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IF1;
			halted <= 1'b0;
		end else if (!halted) begin
			state <= nextState;
			if (state == EX && isHlt) begin
				halted <= 1'b1;
			end
		end
	end

	// next PC is formed with an add in IF3
	always_comb begin
		ctrl = dec;
		ctrl.state = state;
		if (state == IF3) begin
			ctrl.aluOp = ALU_ADD;
		end
		ctrl.regWrite = dec.regWrite && (state == WB);
		ctrl.halt = halted;
	end

endmodule

`default_nettype wire

// ==== hw/cpuPkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpuPkg;

	// data, address or instruction word
	typedef logic [`WORD_SIZE-1:0] word_t;

	typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;

	// instruction fields
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASSB
	} aluOp_t;

	// one cycle per state
	typedef enum logic [2:0] {
		IF1,
		IF2,
		IF3,
		EX,
		MEM1,
		MEM2,
		WB
	} microState_t;

	// controls for the current cycle
	typedef struct packed {
		microState_t state;
		aluOp_t aluOp;
		logic aluSrcImm;
		logic regDst;
		logic regWrite;
		logic memToReg;
		logic linkToReg;
		logic memRead;
		logic memWrite;
		logic branch;
		logic jump;
		logic jumpReg;
		logic wwd;
		logic halt;
	} ctrlWord_t;

endpackage

`default_nettype wire

// ==== hw/cpuTop.sv ====
`default_nettype none

module cpuTop import cpuPkg::*; (
	input logic clk,
	input logic reset_n,
	output logic readM,
	output logic writeM,
	output word_t address,
	output word_t writeData,
	input word_t readData,
	output word_t outputPort,
	output logic halted
);

	ctrlWord_t ctrl;
	word_t instruction;

	controlUnit i_controlUnit (
		.clk(clk),
		.reset_n(reset_n),
		.instruction(instruction),
		.ctrl(ctrl),
		.halted(halted)
	);

	datapath i_datapath (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl),
		.instruction(instruction),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.writeData(writeData),
		.readData(readData),
		.outputPort(outputPort)
	);

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`default_nettype none

`include "cpu_defines.svh"

module datapath import cpuPkg::*; (
	input logic clk,
	input logic reset_n,
	input ctrlWord_t ctrl,
	output word_t instruction,
	output logic readM,
	output logic writeM,
	output word_t address,
	output word_t writeData,
	input word_t readData,
	output word_t outputPort
);

	opcode_t opcode;
	regIdx_t rs;
	regIdx_t rt;
	regIdx_t rd;
	regIdx_t writeIdx;
	logic [7:0] imm8;
	logic [11:0] target;
	word_t pc;
	word_t nextPc;
	word_t rsData;
	word_t rtData;
	word_t immValue;
	word_t aluA;
	word_t aluB;
	word_t aluResult;
	word_t resultReg;
	word_t storeData;
	word_t loadData;
	word_t regWriteData;
	logic branchTaken;

	// instruction fields
	assign opcode = instruction[15:12];
	assign rs = instruction[11:10];
	assign rt = instruction[9:8];
	assign rd = instruction[7:6];
	assign imm8 = instruction[7:0];
	assign target = instruction[11:0];

	always_comb begin
		case (opcode)
			`ORI_OP: immValue = {8'h00, imm8};
			`LHI_OP: immValue = {imm8, 8'h00};
			default: immValue = {{8{imm8[7]}}, imm8};
		endcase
	end

	// IF3 reuses the ALU for PC plus one
	assign aluA = (ctrl.state == IF3) ? pc : (ctrl.branch ? nextPc : rsData);
	assign aluB = (ctrl.state == IF3) ? word_t'(1) : (ctrl.aluSrcImm ? immValue : rtData);

	always_comb begin
		case (opcode)
			`BNE_OP: branchTaken = (rsData != rtData);
			`BEQ_OP: branchTaken = (rsData == rtData);
			`BGZ_OP: branchTaken = ($signed(rsData) > 0);
			`BLZ_OP: branchTaken = ($signed(rsData) < 0);
			default: branchTaken = 1'b0;
		endcase
	end

	// links always go to register 2
	assign writeIdx = ctrl.linkToReg ? regIdx_t'(2) : (ctrl.regDst ? rd : rt);
	assign regWriteData = ctrl.memToReg ? loadData : resultReg;

	registerFile i_registerFile (
		.clk(clk),
		.reset_n(reset_n),
		.readIdxA(rs),
		.readIdxB(rt),
		.writeIdx(writeIdx),
		.writeData(regWriteData),
		.writeEn(ctrl.regWrite),
		.dataA(rsData),
		.dataB(rtData)
	);

	aluUnit i_aluUnit (
		.a(aluA),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.overflow()
	);

	// fetch uses the PC and memory states use the latched ALU result
	assign address = (ctrl.state == IF1 || ctrl.state == IF2) ? pc : resultReg;
	assign writeData = storeData;

	// strobes are registered and go high in the cycle after IF1 or MEM1
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			nextPc <= '0;
			readM <= 1'b0;
			writeM <= 1'b0;
			instruction <= '0;
			outputPort <= '0;
		end else if (!ctrl.halt) begin
			readM <= 1'b0;
			writeM <= 1'b0;
			case (ctrl.state)
				IF1: begin
					pc <= nextPc;
					readM <= 1'b1;
				end
				IF2: begin
					instruction <= readData;
				end
				IF3: begin
					nextPc <= aluResult;
				end
				EX: begin
					if (ctrl.branch && branchTaken) begin
						nextPc <= aluResult;
					end else if (ctrl.jump) begin
						nextPc <= {nextPc[`WORD_SIZE-1:`WORD_SIZE-4], target};
					end else if (ctrl.jumpReg) begin
						nextPc <= rsData;
					end
					if (ctrl.wwd) begin
						outputPort <= rsData;
					end
				end
				MEM1: begin
					readM <= ctrl.memRead;
					writeM <= ctrl.memWrite;
				end
				default: ;
			endcase
		end
	end

	// EX result or the return address for links
	always_ff @(posedge clk) begin
		if (ctrl.state == EX) begin
			resultReg <= ctrl.linkToReg ? nextPc : aluResult;
			storeData <= rtData;
		end
		if (ctrl.state == MEM2 && ctrl.memRead) begin
			loadData <= readData;
		end
	end

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`default_nettype none

`include "cpu_defines.svh"

module registerFile import cpuPkg::*; (
	input logic clk,
	input logic reset_n,
	input regIdx_t readIdxA,
	input regIdx_t readIdxB,
	input regIdx_t writeIdx,
	input word_t writeData,
	input logic writeEn,
	output word_t dataA,
	output word_t dataB
);

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeIdx] <= writeData;
		end
	end

	// asynchronous read ports
	assign dataA = regs[readIdxA];
	assign dataB = regs[readIdxB];

endmodule

`default_nettype wire

// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// word width for data, address and instruction
`define WORD_SIZE 16
`define NUM_REGS 4

// opcodes in instruction[15:12]
`define BNE_OP 4'd0
`define BEQ_OP 4'd1
`define BGZ_OP 4'd2
`define BLZ_OP 4'd3
`define ADI_OP 4'd4
`define ORI_OP 4'd5
`define LHI_OP 4'd6
`define LWD_OP 4'd7
`define SWD_OP 4'd8
`define JMP_OP 4'd9
`define JAL_OP 4'd10
`define RTYPE_OP 4'd15

// function codes in instruction[5:0], register type only
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_NOT 6'd4
`define FUNC_TCP 6'd5
`define FUNC_SHL 6'd6
`define FUNC_SHR 6'd7
`define FUNC_JPR 6'd25
`define FUNC_JRL 6'd26
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`endif
